//--- all.f
src/arb_pkg.sv
src/arb_req_if.sv
src/client_port.sv
src/rr_arbiter_ppc.sv
src/bus_out_stage.sv
src/arb_mux_top.sv
dv/tb_arb_mux.sv

//--- Bender.yml
package:
  name: arb_mux

dependencies: {}

sources:
  # Design, package first
  - files:
      - src/arb_pkg.sv
      - src/arb_req_if.sv
      - src/client_port.sv
      - src/rr_arbiter_ppc.sv
      - src/bus_out_stage.sv
      - src/arb_mux_top.sv

  # Testbench
  - target: test
    files:
      - dv/tb_arb_mux.sv

//--- dv/tb_arb_mux.sv
// Bus request multiplexer testbench
`default_nettype none
`timescale 1ns/1ns

module tb_arb_mux;
  import arb_pkg::*;

  localparam int NUM_CLIENTS = 4;
  localparam int DATA_W      = 32;
  localparam int CLK_PERIOD  = 20;
  localparam int SEED        = 32'hcbb9_5748;

  // Commands per client in each phase
  localparam int FAIR_CMDS       = 12;
  localparam int SPARSE_CMDS     = 16;
  localparam int BP_CMDS         = 16;
  localparam int CMDS_PER_CLIENT = FAIR_CMDS + SPARSE_CMDS + BP_CMDS;
  localparam int TOTAL_CMDS      = NUM_CLIENTS * CMDS_PER_CLIENT;
  // Gap, handshake, contention and stall cycles of one command at worst
  localparam int WORST_CYCLES    = 40;
  localparam int TIMEOUT_NS      = 4 * TOTAL_CMDS * WORST_CYCLES * CLK_PERIOD;

  logic                   clk_i;
  logic                   rst_ni;
  logic [NUM_CLIENTS-1:0] clt_req_i;
  arb_op_e                clt_op_i   [NUM_CLIENTS];
  logic [DATA_W-1:0]      clt_data_i [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] clt_ack_o;
  logic                   out_valid_o;
  arb_op_e                out_op_o;
  logic [DATA_W-1:0]      out_data_o;
  logic [1:0]             out_src_o;
  logic                   out_ready_i;

  // Run control
  int   phase;
  logic check_rr;
  logic bp_mode;
  int   rx_count;

  // Scoreboard, opcode sent per client and sequence number
  arb_op_e sent_op [NUM_CLIENTS][CMDS_PER_CLIENT];
  int      sent_cnt [NUM_CLIENTS];
  int      exp_seq  [NUM_CLIENTS];

  // Previous cycle as seen by the compare process
  logic [NUM_CLIENTS-1:0] ack_prev;
  logic [NUM_CLIENTS-1:0] req_prev;
  logic [NUM_CLIENTS-1:0] pend;
  int                     last_idx;
  logic                   valid_prev;
  logic                   ready_prev;
  arb_op_e                op_prev;
  logic [DATA_W-1:0]      data_prev;
  logic [1:0]             src_prev;

  arb_mux_top #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .DATA_W      (DATA_W)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clt_req_i   (clt_req_i),
    .clt_op_i    (clt_op_i),
    .clt_data_i  (clt_data_i),
    .clt_ack_o   (clt_ack_o),
    .out_valid_o (out_valid_o),
    .out_op_o    (out_op_o),
    .out_data_o  (out_data_o),
    .out_src_o   (out_src_o),
    .out_ready_i (out_ready_i)
  );

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Lowest waiting client above the last grant, else lowest waiting
  function automatic int next_rr(input logic [NUM_CLIENTS-1:0] waiting, input int last);
    int i;
    int above;
    int lowest;
    above  = -1;
    lowest = -1;
    for (i = 0; i < NUM_CLIENTS; i++) begin
      if (waiting[i]) begin
        if (lowest < 0) lowest = i;
        if (above < 0 && i > last) above = i;
      end
    end
    return (above >= 0) ? above : lowest;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Clock, sink ready and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Sink always ready, random stalls in the back-pressure phase
  initial begin
    integer seed_r;
    seed_r      = SEED + NUM_CLIENTS;
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      if (bp_mode) begin
        out_ready_i <= 1'($random(seed_r));
      end else begin
        out_ready_i <= 1'b1;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: not all commands reached the sink within %0d ns", TIMEOUT_NS);
    $display(">>> FAIL");
    $fatal(1, "Simulation timed out");
  end

  //////////////////////////////////////////////////////////////////////////
  // Clients
  //////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_CLIENTS; g++) begin : gen_clients
    initial begin
      integer  seed_c;
      int      n;
      int      gap;
      arb_op_e op;
      seed_c        = SEED + g;
      sent_cnt[g]   = 0;
      clt_req_i[g]  = 1'b0;
      clt_op_i[g]   = OP_NOP;
      clt_data_i[g] = '0;
      for (n = 0; n < CMDS_PER_CLIENT; n++) begin
        // Continuous, then sparse with long gaps, then short gaps under stalls
        if (n == 0) wait (phase >= 1);
        if (n == FAIR_CMDS) wait (phase >= 2);
        if (n == FAIR_CMDS + SPARSE_CMDS) wait (phase >= 3);
        if (n < FAIR_CMDS) begin
          gap = 0;
        end else if (n < FAIR_CMDS + SPARSE_CMDS) begin
          gap = $random(seed_c) & 15;
        end else begin
          gap = $random(seed_c) & 3;
        end
        @(posedge clk_i);
        repeat (gap) @(posedge clk_i);
        op             = arb_op_e'(2'($random(seed_c)));
        sent_op[g][n]  = op;
        sent_cnt[g]    = n + 1;
        clt_op_i[g]   <= op;
        // Source in the top byte, sequence number below
        clt_data_i[g] <= {8'(g), (DATA_W - 8)'(n)};
        @(posedge clk_i);
        clt_req_i[g]  <= 1'b1;
        do @(posedge clk_i); while (!clt_ack_o[g]);
        clt_req_i[g]  <= 1'b0;
        do @(posedge clk_i); while (clt_ack_o[g]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : compare_proc
    logic [NUM_CLIENTS-1:0] rose;
    int i;
    int got_idx;
    int src;
    int seq;
    if (!rst_ni) begin
      ack_prev   = '0;
      req_prev   = '0;
      pend       = '0;
      last_idx   = NUM_CLIENTS - 1;
      valid_prev = 1'b0;
      ready_prev = 1'b0;
      rx_count   = 0;
      for (i = 0; i < NUM_CLIENTS; i++) exp_seq[i] = 0;
    end else begin
      rose = clt_ack_o & ~ack_prev;
      // Four-phase rules, ack follows req one cycle late once raised
      for (i = 0; i < NUM_CLIENTS; i++) begin
        if (rose[i]) check_val("clt_req_i at ack rise", clt_req_i[i], 1'b1);
        if (ack_prev[i]) check_val("clt_ack_o", clt_ack_o[i], req_prev[i]);
      end
      check_val("clt_ack_o rises per cycle", $countones(rose) <= 1, 1'b1);

      // Stalled sink, contents hold and no grant may happen
      if (valid_prev && !ready_prev) begin
        check_val("out_valid_o", out_valid_o, 1'b1);
        check_val("out_op_o", out_op_o, op_prev);
        check_val("out_data_o", out_data_o, data_prev);
        check_val("out_src_o", out_src_o, src_prev);
        check_val("clt_ack_o rise under stall", rose, '0);
      end

      // An ack rise marks a grant in the cycle before
      got_idx = NUM_CLIENTS;
      for (i = 0; i < NUM_CLIENTS; i++) begin
        if (rose[i]) got_idx = i;
      end
      if (got_idx < NUM_CLIENTS) check_val("granted client waiting", pend[got_idx], 1'b1);
      if (check_rr && pend != '0) begin
        check_val("granted client", got_idx, next_rr(pend, last_idx));
      end
      if (got_idx < NUM_CLIENTS) last_idx = got_idx;

      if (out_valid_o && out_ready_i) begin
        src = out_data_o[DATA_W-1 -: 8];
        seq = out_data_o[DATA_W-9:0];
        check_val("out_src_o", out_src_o, src);
        check_val("transfer of a sent command", exp_seq[src] < sent_cnt[src], 1'b1);
        check_val("out_data_o sequence", seq, exp_seq[src]);
        check_val("out_op_o", out_op_o, sent_op[src][seq]);
        exp_seq[src]++;
        rx_count++;
      end

      // Port offers a command the cycle after it sees req while idle
      pend       = (pend & ~rose) | (req_prev & ~ack_prev & ~pend);
      ack_prev   = clt_ack_o;
      req_prev   = clt_req_i;
      valid_prev = out_valid_o;
      ready_prev = out_ready_i;
      op_prev    = out_op_o;
      data_prev  = out_data_o;
      src_prev   = out_src_o;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    rst_ni   = 1'b0;
    phase    = 0;
    check_rr = 1'b1;
    bp_mode  = 1'b0;
    repeat (3) @(posedge clk_i);
    check_val("clt_ack_o after reset", clt_ack_o, '0);
    check_val("out_valid_o after reset", out_valid_o, 1'b0);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    phase = 1;
    wait (rx_count == NUM_CLIENTS * FAIR_CMDS);
    @(negedge clk_i);
    phase = 2;
    wait (rx_count == NUM_CLIENTS * (FAIR_CMDS + SPARSE_CMDS));
    // Held winners under stalls may differ from plain rotation
    @(negedge clk_i);
    check_rr = 1'b0;
    bp_mode  = 1'b1;
    phase    = 3;
    wait (rx_count == TOTAL_CMDS);
    repeat (10) @(posedge clk_i);
    check_val("sink transfers", rx_count, TOTAL_CMDS);
    for (i = 0; i < NUM_CLIENTS; i++) begin
      check_val("commands delivered per client", exp_seq[i], CMDS_PER_CLIENT);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule : tb_arb_mux

`default_nettype wire

//--- src/arb_mux_top.sv
// Shared bus request multiplexer
`default_nettype none
`timescale 1ns/1ns

module arb_mux_top
  import arb_pkg::*;
#(
  parameter int unsigned NUM_CLIENTS = NumClients,
  parameter int unsigned DATA_W      = DataWidth,
  localparam int unsigned IdxW       = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,

  // Client side, one four-phase handshake per client
  input  wire  [NUM_CLIENTS-1:0] clt_req_i,
  input  arb_op_e                clt_op_i   [NUM_CLIENTS],
  input  wire  [DATA_W-1:0]      clt_data_i [NUM_CLIENTS],
  output logic [NUM_CLIENTS-1:0] clt_ack_o,

  // Sink side, valid/ready
  output logic                   out_valid_o,
  output arb_op_e                out_op_o,
  output logic [DATA_W-1:0]      out_data_o,
  output logic [IdxW-1:0]        out_src_o,
  input  wire                    out_ready_i
);

  // Arbiter to output stage
  logic              arb_valid;
  logic              arb_ready;
  arb_op_e           arb_op;
  logic [DATA_W-1:0] arb_data;
  logic [IdxW-1:0]   arb_idx;

  arb_req_if #(.DATA_W(DATA_W)) req_bus [NUM_CLIENTS] ();

  ////////////////////////////////////////////////////////////////////////////
  // Client ports
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_ports
    client_port #(
      .DATA_W (DATA_W)
    ) i_port (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .clt_req_i  (clt_req_i[i]),
      .clt_op_i   (clt_op_i[i]),
      .clt_data_i (clt_data_i[i]),
      .clt_ack_o  (clt_ack_o[i]),
      .req_if     (req_bus[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration and output register
  ////////////////////////////////////////////////////////////////////////////

  rr_arbiter_ppc #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .DATA_W      (DATA_W)
  ) i_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_if  (req_bus),
    .valid_o (arb_valid),
    .op_o    (arb_op),
    .data_o  (arb_data),
    .idx_o   (arb_idx),
    .ready_i (arb_ready)
  );

  bus_out_stage #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .DATA_W      (DATA_W)
  ) i_out_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (arb_valid),
    .in_op_i     (arb_op),
    .in_data_i   (arb_data),
    .in_idx_i    (arb_idx),
    .in_ready_o  (arb_ready),
    .out_valid_o (out_valid_o),
    .out_op_o    (out_op_o),
    .out_data_o  (out_data_o),
    .out_src_o   (out_src_o),
    .out_ready_i (out_ready_i)
  );

endmodule : arb_mux_top

`default_nettype wire

//--- src/bus_out_stage.sv
// Sink-side output register
`default_nettype none
`timescale 1ns/1ns

module bus_out_stage
  import arb_pkg::*;
#(
  parameter int unsigned NUM_CLIENTS = NumClients,
  parameter int unsigned DATA_W      = DataWidth,
  localparam int unsigned IdxW       = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1
) (
  input  wire               clk_i,
  input  wire               rst_ni,

  // From the arbiter
  input  wire               in_valid_i,
  input  arb_op_e           in_op_i,
  input  wire  [DATA_W-1:0] in_data_i,
  input  wire  [IdxW-1:0]   in_idx_i,
  output logic              in_ready_o,

  // Toward the external sink
  output logic              out_valid_o,
  output arb_op_e           out_op_o,
  output logic [DATA_W-1:0] out_data_o,
  output logic [IdxW-1:0]   out_src_o,
  input  wire               out_ready_i
);

  logic              full_q;
  logic              load;
  arb_op_e           op_q;
  logic [DATA_W-1:0] data_q;
  logic [IdxW-1:0]   src_q;

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////////////////////////////////////////

  // Free slot, or the slot empties this cycle, keeps one item per cycle
  assign in_ready_o = ~full_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      // Sink took the entry and nothing new arrives
      full_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  // Contents only change on load, so they hold while the sink stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      op_q   <= in_op_i;
      data_q <= in_data_i;
      src_q  <= in_idx_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_op_o    = op_q;
  assign out_data_o  = data_q;
  assign out_src_o   = src_q;

endmodule : bus_out_stage

`default_nettype wire

//--- src/rr_arbiter_ppc.sv
// Round-robin prefix arbiter
`default_nettype none
`timescale 1ns/1ns

module rr_arbiter_ppc
  import arb_pkg::*;
#(
  parameter int unsigned NUM_CLIENTS = NumClients,
  parameter int unsigned DATA_W      = DataWidth,
  localparam int unsigned IdxW       = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1
) (
  input  wire              clk_i,
  input  wire              rst_ni,

  // One link per client port
  arb_req_if.arb           req_if [NUM_CLIENTS],

  // Winning command toward the output stage
  output logic             valid_o,
  output arb_op_e          op_o,
  output logic [DATA_W-1:0] data_o,
  output logic [IdxW-1:0]  idx_o,
  input  wire              ready_i
);

  // Flattened view of the interface array
  logic [NUM_CLIENTS-1:0] req_vec;
  logic [NUM_CLIENTS-1:0] gnt_vec;
  arb_op_e                op_arr   [NUM_CLIENTS];
  logic [DATA_W-1:0]      data_arr [NUM_CLIENTS];

  for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_flatten
    assign req_vec[i]   = req_if[i].req;
    assign op_arr[i]    = req_if[i].op;
    assign data_arr[i]  = req_if[i].data;
    assign req_if[i].gnt = gnt_vec[i];
  end

  if (NUM_CLIENTS == 1) begin : gen_single

    // Nothing to arbitrate
    assign valid_o    = req_vec[0];
    assign op_o       = op_arr[0];
    assign data_o     = data_arr[0];
    assign idx_o      = '0;
    assign gnt_vec[0] = valid_o & ready_i;

  end else begin : gen_multi

    logic [NUM_CLIENTS-1:0] mask_q;
    logic [NUM_CLIENTS-1:0] masked_req;
    logic [NUM_CLIENTS-1:0] arb_req;
    logic [NUM_CLIENTS-1:0] ppc;
    logic [NUM_CLIENTS-1:0] winner;

    //////////////////////////////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////////////////////////////

    // Thermometer mask keeps only clients above the last winner
    assign masked_req = mask_q & req_vec;
    // Wrap around when nobody above the last winner is waiting
    assign arb_req    = (|masked_req) ? masked_req : req_vec;

    // Prefix-OR chain, written linearly and left to synthesis to balance
    always_comb begin
      ppc[0] = arb_req[0];
      for (int i = 1; i < NUM_CLIENTS; i++) begin
        ppc[i] = ppc[i-1] | arb_req[i];
      end
    end

    // Leading one of the chain is the one-hot winner
    assign winner  = ppc ^ {ppc[NUM_CLIENTS-2:0], 1'b0};
    assign valid_o = |req_vec;
    assign gnt_vec = ready_i ? winner : '0;

    //////////////////////////////////////////////////////////////////////////
    // Mask register
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mask_q <= '0;
      end else if (valid_o && ready_i) begin
        // Next search starts above the winner
        mask_q <= {ppc[NUM_CLIENTS-2:0], 1'b0};
      end else if (valid_o && !ready_i) begin
        // Sink stalled, mask starts at the winner so it stays selected
        mask_q <= ppc;
      end
    end

    //////////////////////////////////////////////////////////////////////////
    // Winner mux and index encoder
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
      op_o   = OP_NOP;
      data_o = '0;
      idx_o  = '0;
      for (int unsigned i = 0; i < NUM_CLIENTS; i++) begin
        if (winner[i]) begin
          op_o   = op_arr[i];
          data_o = data_arr[i];
          idx_o  = IdxW'(i);
        end
      end
    end

  end

endmodule : rr_arbiter_ppc

`default_nettype wire

//--- src/client_port.sv
// Four-phase client port
`default_nettype none
`timescale 1ns/1ns

module client_port
  import arb_pkg::*;
#(
  parameter int unsigned DATA_W = DataWidth
) (
  input  wire               clk_i,
  input  wire               rst_ni,

  // Four-phase handshake with the client
  input  wire               clt_req_i,
  input  arb_op_e           clt_op_i,
  input  wire  [DATA_W-1:0] clt_data_i,
  output logic              clt_ack_o,

  // Pending command toward the arbiter
  arb_req_if.port           req_if
);

  port_state_e       state_q, state_d;
  logic              capture;

  // Holding registers for the captured command
  arb_op_e           op_q;
  logic [DATA_W-1:0] data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    case (state_q)
      // New request, op and data are stable while req is high
      ST_IDLE: begin
        if (clt_req_i) begin
          state_d = ST_PEND;
          capture = 1'b1;
        end
      end
      // Offer the command until the arbiter takes it
      ST_PEND: begin
        if (req_if.gnt) begin
          state_d = ST_ACK;
        end
      end
      // Ack just rose, client may already have released req
      ST_ACK: begin
        if (clt_req_i) begin
          state_d = ST_WAIT_LOW;
        end else begin
          state_d = ST_IDLE;
        end
      end
      // Hold ack until the client drops req
      ST_WAIT_LOW: begin
        if (!clt_req_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command is only loaded on request entry
  always_ff @(posedge clk_i) begin
    if (capture) begin
      op_q   <= clt_op_i;
      data_q <= clt_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Both are decoded from the state register, so glitch free
  assign req_if.req  = (state_q == ST_PEND);
  assign req_if.op   = op_q;
  assign req_if.data = data_q;

  assign clt_ack_o = (state_q == ST_ACK) || (state_q == ST_WAIT_LOW);

endmodule : client_port

`default_nettype wire

//--- src/arb_req_if.sv
// Client port to arbiter link
`default_nettype none
`timescale 1ns/1ns

interface arb_req_if
  import arb_pkg::*;
#(
  parameter int unsigned DATA_W = DataWidth
) ();

  // Port has a command waiting for the bus
  logic              req;
  // Pending command
  arb_op_e           op;
  logic [DATA_W-1:0] data;
  // Arbiter accepted this port's command in the current cycle
  logic              gnt;

  // Client port side
  modport port (
    output req,
    output op,
    output data,
    input  gnt
  );

  // Arbiter side
  modport arb (
    input  req,
    input  op,
    input  data,
    output gnt
  );

endinterface : arb_req_if

`default_nettype wire

//--- src/arb_pkg.sv
// Bus request multiplexer definitions
`default_nettype none

package arb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////////////////////

  // Data word carried with every command
  parameter int unsigned DataWidth = 32;

  // Clients sharing the bus
  parameter int unsigned NumClients = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Command and FSM encodings
  ////////////////////////////////////////////////////////////////////////////

  // Command opcode as seen on the client side and at the sink
  typedef enum logic [1:0] {
    OP_NOP   = 2'b00,
    OP_READ  = 2'b01,
    OP_WRITE = 2'b10,
    OP_FLUSH = 2'b11
  } arb_op_e;

  // Client port FSM
  // IDLE waits for req, PEND holds the command toward the arbiter,
  // ACK is the first ack cycle, WAIT_LOW keeps ack up until req drops
  typedef enum logic [1:0] {
    ST_IDLE     = 2'b00,
    ST_PEND     = 2'b01,
    ST_ACK      = 2'b10,
    ST_WAIT_LOW = 2'b11
  } port_state_e;

endpackage : arb_pkg

`default_nettype wire
